// File: logic/dds_reg_pkg.sv
package dds_reg_pkg;

	////////////////////////////////////////////////////////////
	// chip register map

	localparam logic [12:0] freq_addr  = 13'h01ab;	// ftw, top byte of six
	localparam logic [12:0] phase_addr = 13'h01ad;	// phase offset, upper byte
	localparam logic [12:0] amp_addr   = 13'h040c;	// dac full scale current, upper byte

	// byte count field of the header
	localparam logic [1:0] bytes_two    = 2'd1;	// two bytes then csb
	localparam logic [1:0] bytes_stream = 2'd3;	// stream until csb rises

	////////////////////////////////////////////////////////////
	// instruction layout, msb goes out first

	typedef struct packed {
		logic        read_not_write;	// 0 for every write here
		logic [1:0]  byte_count;
		logic [12:0] address;	// msb address, chip counts down
	} instr_header_t;

	typedef struct packed {
		instr_header_t header;
		logic [47:0]   data;	// full tuning word
	} long_write_t;

	typedef struct packed {
		instr_header_t header;
		logic [15:0]   data;	// zero extended phase or amp
		logic [31:0]   pad;	// never shifted
	} short_write_t;

	// one 64 bit shift word, two readings
	typedef union packed {
		long_write_t  long_write;
		short_write_t short_write;
	} instr_word_t;

endpackage

// File: logic/dds_ctrl_pkg.sv
package dds_ctrl_pkg;

	// which register a write targets, also the done pulse it raises
	typedef enum logic [1:0] {
		wr_none  = 2'd0,
		wr_freq  = 2'd1,
		wr_phase = 2'd2,
		wr_amp   = 2'd3
	} write_kind_t;

	////////////////////////////////////////////////////////////
	// stage to stage bundles

	// decode -> execute
	typedef struct packed {
		logic                    start;	// one cycle
		write_kind_t             kind;
		logic [6:0]              len;	// bits to shift, 64 or 32
		dds_reg_pkg::instr_word_t word;
	} tx_cmd_t;

	// execute -> result
	typedef struct packed {
		logic        sent;	// one cycle, csb just rose
		write_kind_t kind;
	} tx_status_t;

endpackage

// File: logic/dds_update_decode.sv
`timescale 1ns/1ns

module dds_update_decode (
	input  logic                  clk_in,
	input  logic                  reset_in,
	input  logic [47:0]           freq,
	input  logic [13:0]           phase,
	input  logic [9:0]            amp,
	input  logic                  freq_valid,
	input  logic                  phase_valid,
	input  logic                  amp_valid,
	input  logic                  shift_busy,	// execute is shifting
	input  logic                  update_busy,	// result is waiting on io_update
	output dds_ctrl_pkg::tx_cmd_t cmd
);

	logic [47:0] freq_q;	// latest freq value
	logic [13:0] phase_q;
	logic [9:0]  amp_q;
	logic        freq_pend;	// value waiting to go out
	logic        phase_pend;
	logic        amp_pend;
	logic        idle;

	// start still high counts as in flight, busy levels rise one edge later
	assign idle = ~shift_busy & ~update_busy & ~cmd.start;

	function automatic dds_reg_pkg::instr_header_t make_header(
		input logic [12:0] addr,
		input logic [1:0]  count
	);
		dds_reg_pkg::instr_header_t hdr;
		hdr.read_not_write = 1'b0;	// write
		hdr.byte_count     = count;
		hdr.address        = addr;
		return hdr;
	endfunction

	////////////////////////////////////////////////////////////
	// pending values, a strobe always overwrites

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			freq_pend  <= 1'b0;
			phase_pend <= 1'b0;
			amp_pend   <= 1'b0;
		end else begin
			if (idle) begin	// clear only the one picked below
				if (freq_pend)
					freq_pend <= 1'b0;
				else if (phase_pend)
					phase_pend <= 1'b0;
				else if (amp_pend)
					amp_pend <= 1'b0;
			end
			if (freq_valid)
				freq_pend <= 1'b1;	// wins over the clear above
			if (phase_valid)
				phase_pend <= 1'b1;
			if (amp_valid)
				amp_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (freq_valid)
			freq_q <= freq;
		if (phase_valid)
			phase_q <= phase;
		if (amp_valid)
			amp_q <= amp;
	end

	////////////////////////////////////////////////////////////
	// command builder, freq > phase > amp

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cmd.start <= 1'b0;
			cmd.kind  <= dds_ctrl_pkg::wr_none;
		end else begin
			cmd.start <= 1'b0;	// single cycle
			if (idle && freq_pend) begin
				cmd.start <= 1'b1;
				cmd.kind  <= dds_ctrl_pkg::wr_freq;
			end else if (idle && phase_pend) begin
				cmd.start <= 1'b1;
				cmd.kind  <= dds_ctrl_pkg::wr_phase;
			end else if (idle && amp_pend) begin
				cmd.start <= 1'b1;
				cmd.kind  <= dds_ctrl_pkg::wr_amp;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (freq_pend) begin
			cmd.len                    <= 7'd64;
			cmd.word.long_write.header <= make_header(dds_reg_pkg::freq_addr,
				dds_reg_pkg::bytes_stream);
			cmd.word.long_write.data   <= freq_q;
		end else if (phase_pend) begin
			cmd.len                     <= 7'd32;
			cmd.word.short_write.header <= make_header(dds_reg_pkg::phase_addr,
				dds_reg_pkg::bytes_two);
			cmd.word.short_write.data   <= {2'b00, phase_q};
			cmd.word.short_write.pad    <= '0;
		end else if (amp_pend) begin
			cmd.len                     <= 7'd32;
			cmd.word.short_write.header <= make_header(dds_reg_pkg::amp_addr,
				dds_reg_pkg::bytes_two);
			cmd.word.short_write.data   <= {6'd0, amp_q};
			cmd.word.short_write.pad    <= '0;
		end
	end

endmodule

// File: logic/dds_serial_execute.sv
`timescale 1ns/1ns

module dds_serial_execute #(
	parameter int SCLK_HALF = 2	// clk_in cycles per sclk half period
) (
	input  logic                     clk_in,
	input  logic                     reset_in,
	input  dds_ctrl_pkg::tx_cmd_t    cmd,
	output logic                     sclk,
	output logic                     csb,
	output logic                     sdio,
	output dds_ctrl_pkg::tx_status_t status,
	output logic                     shift_busy
);

	localparam int DIV_W = $clog2(SCLK_HALF + 1);

	logic [63:0]               shreg;	// msb is on the wire
	logic [6:0]                len_q;
	logic [6:0]                bit_cnt;	// bits finished so far
	logic [DIV_W-1:0]          div;	// half period divider
	dds_ctrl_pkg::write_kind_t kind_q;
	logic                      half_done;
	logic                      load;
	logic                      last_bit;

	assign half_done = (div == DIV_W'(SCLK_HALF - 1));
	assign load      = cmd.start & ~shift_busy;
	assign last_bit  = (bit_cnt == len_q - 7'd1);
	assign sdio      = ~csb & shreg[63];	// quiet low between writes

	////////////////////////////////////////////////////////////
	// sclk, csb and bit count

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			csb         <= 1'b1;
			sclk        <= 1'b0;
			shift_busy  <= 1'b0;
			div         <= '0;
			bit_cnt     <= '0;
			status.sent <= 1'b0;
			status.kind <= dds_ctrl_pkg::wr_none;
		end else begin
			status.sent <= 1'b0;
			if (load) begin
				csb        <= 1'b0;	// first bit already on sdio
				shift_busy <= 1'b1;
				sclk       <= 1'b0;
				div        <= '0;
				bit_cnt    <= '0;
			end else if (shift_busy) begin
				if (half_done) begin
					div <= '0;
					if (!sclk) begin
						sclk <= 1'b1;	// chip samples here
					end else begin
						sclk <= 1'b0;	// falling, next bit
						if (last_bit) begin
							csb         <= 1'b1;
							shift_busy  <= 1'b0;
							status.sent <= 1'b1;
							status.kind <= kind_q;
						end else begin
							bit_cnt <= bit_cnt + 7'd1;
						end
					end
				end else begin
					div <= div + DIV_W'(1);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// data path

	always_ff @(posedge clk_in) begin
		if (load) begin
			shreg  <= cmd.word;
			len_q  <= cmd.len;
			kind_q <= cmd.kind;
		end else if (shift_busy && half_done && sclk) begin
			shreg <= {shreg[62:0], 1'b0};	// shift after the rising edge
		end
	end

endmodule

// File: logic/dds_update_result.sv
`timescale 1ns/1ns

module dds_update_result #(
	parameter int SETUP_CYCLES = 2	// csb high to io_update
) (
	input  logic                     clk_in,
	input  logic                     reset_in,
	input  dds_ctrl_pkg::tx_status_t status,
	output logic                     io_update,
	output logic                     freq_done,
	output logic                     phase_done,
	output logic                     amp_done,
	output logic                     update_busy
);

	localparam int CNT_W = $clog2(SETUP_CYCLES + 1);

	logic                      waiting;	// between sent and io_update
	logic [CNT_W-1:0]          cnt;	// cycles left
	dds_ctrl_pkg::write_kind_t kind_q;

	assign io_update   = waiting & (cnt == '0);
	assign freq_done   = io_update & (kind_q == dds_ctrl_pkg::wr_freq);
	assign phase_done  = io_update & (kind_q == dds_ctrl_pkg::wr_phase);
	assign amp_done    = io_update & (kind_q == dds_ctrl_pkg::wr_amp);
	assign update_busy = status.sent | waiting;	// sent cycle too, decode sees it at once

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			waiting <= 1'b0;
			cnt     <= '0;
		end else if (status.sent) begin
			waiting <= 1'b1;
			cnt     <= CNT_W'(SETUP_CYCLES - 1);	// one cycle already gone
		end else if (waiting) begin
			if (cnt == '0)
				waiting <= 1'b0;	// io_update done
			else
				cnt <= cnt - CNT_W'(1);
		end
	end

	always_ff @(posedge clk_in) begin
		if (status.sent)
			kind_q <= status.kind;
	end

endmodule

// File: logic/dds_controller.sv
`timescale 1ns/1ns

module dds_controller #(
	parameter int SCLK_HALF    = 2,	// clk_in cycles per sclk half
	parameter int SETUP_CYCLES = 2	// csb rise to io_update
) (
	input  logic        clk_in,
	input  logic        reset_in,
	input  logic [47:0] freq,	// tuning word
	input  logic [13:0] phase,
	input  logic [9:0]  amp,
	input  logic        freq_valid,
	input  logic        phase_valid,
	input  logic        amp_valid,
	output logic        sclk,	// to chip
	output logic        csb,
	output logic        sdio,
	output logic        io_update,
	output logic        freq_done,	// upstream pulses
	output logic        phase_done,
	output logic        amp_done
);

	dds_ctrl_pkg::tx_cmd_t    tx_cmd;
	dds_ctrl_pkg::tx_status_t tx_status;
	logic                     shift_busy;
	logic                     update_busy;

	////////////////////////////////////////////////////////////
	// decode, execute, result

	dds_update_decode i_decode (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.freq        (freq),
		.phase       (phase),
		.amp         (amp),
		.freq_valid  (freq_valid),
		.phase_valid (phase_valid),
		.amp_valid   (amp_valid),
		.shift_busy  (shift_busy),
		.update_busy (update_busy),
		.cmd         (tx_cmd)
	);

	dds_serial_execute #(.SCLK_HALF(SCLK_HALF)) i_execute (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.cmd        (tx_cmd),
		.sclk       (sclk),
		.csb        (csb),
		.sdio       (sdio),
		.status     (tx_status),
		.shift_busy (shift_busy)
	);

	dds_update_result #(.SETUP_CYCLES(SETUP_CYCLES)) i_result (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.status      (tx_status),
		.io_update   (io_update),
		.freq_done   (freq_done),
		.phase_done  (phase_done),
		.amp_done    (amp_done),
		.update_busy (update_busy)
	);

endmodule

// File: testbench/dds_controller_tb.sv
`timescale 1ns/1ns

module dds_controller_tb;

	localparam int SCLK_HALF    = 2;	// clk_in cycles per sclk half
	localparam int SETUP_CYCLES = 2;	// csb rise to io_update
	localparam int REC_W        = 9;	// hex words per pattern line
	localparam int MAX_REC      = 16;

	typedef struct packed {
		logic [7:0]       mask;	// b0 freq, b1 phase, b2 amp, b3 late phase
		logic [47:0]      freq;
		logic [13:0]      phase;
		logic [9:0]       amp;
		logic [13:0]      late_phase;	// replaces phase mid freq write
		logic [1:0]       n_writes;
		logic [2:0][63:0] words;	// expected in priority order
	} pattern_t;

	logic        clk_in;
	logic        reset_in;
	logic [47:0] freq;
	logic [13:0] phase;
	logic [9:0]  amp;
	logic        freq_valid;
	logic        phase_valid;
	logic        amp_valid;
	logic        sclk;
	logic        csb;
	logic        sdio;
	logic        io_update;
	logic        freq_done;
	logic        phase_done;
	logic        amp_done;

	logic [63:0] pat_mem [0:MAX_REC*REC_W-1];
	logic [63:0] exp_q [$];	// words still to come out
	int          n_rec;
	int          cycle_limit;
	int          cycles = 0;
	int          writes_done = 0;	// io_update pulses seen

	logic        sclk_q;	// monitor history
	logic        csb_q;
	logic [63:0] shift_word;	// bits collected so far
	int          n_bits;
	int          low_cycles;
	int          since_rise;	// edges since csb rose
	logic        armed;	// write ended and io_update owed
	logic [2:0]  exp_done;	// {amp, phase, freq}

	dds_controller #(.SCLK_HALF(SCLK_HALF), .SETUP_CYCLES(SETUP_CYCLES)) i_dds_controller (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.freq        (freq),
		.phase       (phase),
		.amp         (amp),
		.freq_valid  (freq_valid),
		.phase_valid (phase_valid),
		.amp_valid   (amp_valid),
		.sclk        (sclk),
		.csb         (csb),
		.sdio        (sdio),
		.io_update   (io_update),
		.freq_done   (freq_done),
		.phase_done  (phase_done),
		.amp_done    (amp_done)
	);

	////////////////////////////////////////////////////////////
	// helpers

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// byte count 3 streams six data bytes and 1 sends two
	function automatic int bit_len(input logic [63:0] word);
		return (word[62:61] == 2'd3) ? 64 : 32;
	endfunction

	// address field picks the done pulse
	function automatic logic [2:0] done_for(input logic [63:0] word);
		case (word[60:48])
			13'h01ab: return 3'b001;	// ftw
			13'h01ad: return 3'b010;	// phase offset
			13'h040c: return 3'b100;	// dac scale
			default:  return 3'b000;
		endcase
	endfunction

	function automatic pattern_t read_pattern(input int idx);
		pattern_t p;
		int       base;
		base         = idx * REC_W;
		p.mask       = pat_mem[base][7:0];
		p.freq       = pat_mem[base + 1][47:0];
		p.phase      = pat_mem[base + 2][13:0];
		p.amp        = pat_mem[base + 3][9:0];
		p.late_phase = pat_mem[base + 4][13:0];
		p.n_writes   = pat_mem[base + 5][1:0];
		p.words      = {pat_mem[base + 8], pat_mem[base + 7], pat_mem[base + 6]};
		return p;
	endfunction

	task automatic send_pattern(input pattern_t p);
		int target;
		target = writes_done + int'(p.n_writes);
		for (int i = 0; i < int'(p.n_writes); i++)
			exp_q.push_back(p.words[i]);
		@(posedge clk_in);
		#1;
		freq        = p.freq;
		phase       = p.phase;
		amp         = p.amp;
		freq_valid  = p.mask[0];	// all strobes in one cycle
		phase_valid = p.mask[1];
		amp_valid   = p.mask[2];
		@(posedge clk_in);
		#1;
		freq_valid  = 1'b0;
		phase_valid = 1'b0;
		amp_valid   = 1'b0;
		if (p.mask[3]) begin	// overwrite phase while freq shifts
			while (csb) begin
				@(posedge clk_in);
				#1;
			end
			repeat (4) @(posedge clk_in);
			#1;
			phase       = p.late_phase;
			phase_valid = 1'b1;
			@(posedge clk_in);
			#1;
			phase_valid = 1'b0;
		end
		while (writes_done < target)
			@(posedge clk_in);	// until every io_update of this record
		repeat (2) @(posedge clk_in);
	endtask

	////////////////////////////////////////////////////////////
	// clock, timeout, serial monitor

	always #5 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display(">>> FAIL");
			$fatal(1, "simulation timed out after %0d cycles", cycles);
		end
	end

	// sampled mid cycle when all dut outputs have settled
	always @(negedge clk_in) begin
		logic [63:0] expected;
		if (reset_in) begin
			sclk_q     = 1'b0;
			csb_q      = 1'b1;
			shift_word = '0;
			n_bits     = 0;
			low_cycles = 0;
			since_rise = 0;
			armed      = 1'b0;
			exp_done   = '0;
		end else begin
			if (armed)
				since_rise++;
			if (!csb) begin
				low_cycles++;
				if (sclk && !sclk_q) begin	// chip samples on rising sclk
					shift_word = {shift_word[62:0], sdio};
					n_bits++;
				end
			end
			if (csb && !csb_q) begin	// write just ended
				check_equal(64'(exp_q.size() != 0), 64'd1, "write with none expected");
				expected = exp_q.pop_front();
				check_equal(64'(n_bits), 64'(bit_len(expected)), "bits shifted");
				check_equal(64'(low_cycles), 64'(bit_len(expected) * 2 * SCLK_HALF),
					"csb low cycles");
				check_equal(shift_word << (64 - n_bits), expected, "instruction word");
				exp_done   = done_for(expected);
				armed      = 1'b1;
				since_rise = 0;
				shift_word = '0;
				n_bits     = 0;
				low_cycles = 0;
			end
			if (io_update) begin
				check_equal(64'(armed), 64'd1, "io_update without a write");
				check_equal(64'(since_rise), 64'(SETUP_CYCLES), "csb rise to io_update");
				check_equal(64'({amp_done, phase_done, freq_done}), 64'(exp_done), "done pulse");
				armed = 1'b0;	// a second high cycle fails above
				writes_done++;
			end else begin
				check_equal(64'({amp_done, phase_done, freq_done}), 64'd0,
					"done without io_update");
			end
			sclk_q = sclk;
			csb_q  = csb;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		pattern_t p;
		clk_in      = 1'b0;
		reset_in    = 1'b1;
		freq        = '0;
		phase       = '0;
		amp         = '0;
		freq_valid  = 1'b0;
		phase_valid = 1'b0;
		amp_valid   = 1'b0;
		$readmemh("testbench/dds_update_patterns.mem", pat_mem);
		n_rec = 0;
		while (n_rec < MAX_REC && pat_mem[n_rec * REC_W][7:0] != 8'hff)
			n_rec++;	// ff mask ends the list
		// worst case three freq sized writes per record plus reset and idle windows
		cycle_limit = n_rec * 3 * (64 * 2 * SCLK_HALF + SETUP_CYCLES + 8) + 40;
		check_equal(64'(n_rec > 0), 64'd1, "pattern records loaded");
		repeat (3) @(posedge clk_in);
		#1;
		reset_in = 1'b0;
		repeat (20) begin	// quiet bus with nothing pending
			@(negedge clk_in);
			check_equal(64'(csb), 64'd1, "csb while idle");
			check_equal(64'(io_update), 64'd0, "io_update while idle");
		end
		for (int r = 0; r < n_rec; r++) begin
			p = read_pattern(r);
			send_pattern(p);
		end
		repeat (8) begin	// every pending flag cleared, nothing is resent
			@(negedge clk_in);
			check_equal(64'(csb), 64'd1, "csb after the last write");
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: testbench/dds_update_patterns.mem
// one request per line, hex: mask freq phase amp late_phase n_writes word0 word1 word2
// mask b0 freq, b1 phase, b2 amp, b3 late phase; words are header then data, zero padded
// headers: 61ab freq at 01ab, 21ad phase at 01ad, 240c amp at 040c
// single freq write
1 123456789abc 0 0 0 1 61ab123456789abc 0 0
// single phase write, 14 bits zero extended
2 0 1555 0 0 1 21ad155500000000 0 0
// single amp write, 10 bits zero extended
4 0 0 2a5 0 1 240c02a500000000 0 0
// all three in one cycle, freq then phase then amp
7 0f0e0d0c0b0a 3fff 3ff 0 3 61ab0f0e0d0c0b0a 21ad3fff00000000 240c03ff00000000
// second phase strobe during freq shift, only 2abc goes out
b 800000000001 0123 0 2abc 2 61ab800000000001 21ad2abc00000000 0
// phase before amp
6 0 0001 200 0 2 21ad000100000000 240c020000000000 0
// freq all ones
1 ffffffffffff 0 0 0 1 61abffffffffffff 0 0
// freq zero then amp
5 000000000000 0 001 0 2 61ab000000000000 240c000100000000 0
// end of list
ff 0 0 0 0 0 0 0 0

// File: build.f
logic/dds_reg_pkg.sv
logic/dds_ctrl_pkg.sv
logic/dds_update_decode.sv
logic/dds_serial_execute.sv
logic/dds_update_result.sv
logic/dds_controller.sv
testbench/dds_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DDS controller testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ns -f build.f \
	--top-module dds_controller_tb -Mdir obj_dir -o dds_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/dds_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
